/* design/lpf_pkg.sv */
package lpf_pkg;

    // ----------------------------------------
    // Widths and counts
    // ----------------------------------------
    localparam int sample_w     = 16;       // Signed input and output samples
    localparam int coef_w       = 18;       // Signed Q2.16 coefficients
    localparam int coef_frac    = 16;       // Fraction bits dropped at the output
    localparam int acc_w        = 48;       // Accumulator width
    localparam int num_taps     = 5;        // b0 b1 b2 a1 a2
    localparam int drain_cycles = 4;        // Last issue to output strobe

    typedef logic signed [sample_w-1:0] sample_t;
    typedef logic signed [coef_w-1:0]   coef_t;
    typedef logic signed [acc_w-1:0]    acc_t;
    typedef logic [2:0]                 tap_t;   // Tap index or drain count

    // ----------------------------------------
    // Encodings
    // ----------------------------------------
    typedef enum logic [1:0] {
        op_nop  = 2'd0,                     // Hold accumulator
        op_load = 2'd1,                     // Acc takes product
        op_add  = 2'd2,                     // Acc plus product
        op_sub  = 2'd3                      // Acc minus product
    } mac_op_t;

    typedef enum logic [1:0] {
        st_idle  = 2'd0,
        st_issue = 2'd1,
        st_drain = 2'd2
    } seq_state_t;

    // Command into the MAC slice, one per cycle
    typedef struct packed {
        mac_op_t                  op;
        coef_t                    coef;
        logic signed [coef_w-1:0] data;     // Sample, sign-extended to B width
        logic                     last;     // Marks tap 4
    } mac_cmd_t;

    typedef struct packed {
        acc_t acc;
        logic last;                         // Acc holds a finished sum
    } mac_result_t;

endpackage

/* design/lpf_sequencer.sv */
`timescale 1ns/1ps

module lpf_sequencer (
    input  logic clk,
    input  logic reset,
    input  logic in_valid,              // Sample strobe from outside
    input  logic issue_done,            // Fifth tap going out this cycle
    input  logic drain_done,            // Output strobe going out this cycle
    output logic load_x,                // Latch new x0
    output logic issue_en,              // Taps being issued
    output logic busy                   // Sample in flight
);

    lpf_pkg::seq_state_t state;
    lpf_pkg::seq_state_t state_nxt;

    // ----------------------------------------
    // Next state
    // ----------------------------------------
    always_comb begin
        state_nxt = state;                          // Default hold
        case (state)
            lpf_pkg::st_idle: begin
                if (in_valid) begin
                    state_nxt = lpf_pkg::st_issue;  // Accept sample
                end
            end
            lpf_pkg::st_issue: begin
                if (issue_done) begin
                    state_nxt = lpf_pkg::st_drain;  // All five taps out
                end
            end
            lpf_pkg::st_drain: begin
                if (drain_done) begin
                    state_nxt = lpf_pkg::st_idle;   // Pipeline emptied
                end
            end
            default: begin
                state_nxt = lpf_pkg::st_idle;       // Recover from bad encoding
            end
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= lpf_pkg::st_idle;
        end else begin
            state <= state_nxt;
        end
    end

    // ----------------------------------------
    // Outputs
    // ----------------------------------------
    // Strobes during busy fall through here and are lost
    assign load_x   = (state == lpf_pkg::st_idle) && in_valid;
    assign issue_en = (state == lpf_pkg::st_issue);
    assign busy     = (state != lpf_pkg::st_idle);  // Issue and drain

endmodule

/* design/tap_counter.sv */
`timescale 1ns/1ps

module tap_counter (
    input  logic          clk,
    input  logic          reset,
    input  logic          issue_en,     // Issue phase from sequencer
    output lpf_pkg::tap_t tap,          // Tap index, or drain count
    output logic          issue_done,   // Tap 4 this cycle
    output logic          drain_done    // Last drain cycle
);

    localparam lpf_pkg::tap_t tap_last   = lpf_pkg::tap_t'(lpf_pkg::num_taps - 1);
    localparam lpf_pkg::tap_t drain_last = lpf_pkg::tap_t'(lpf_pkg::drain_cycles - 1);

    lpf_pkg::tap_t count;
    logic          draining;            // Drain phase active

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            count    <= '0;
            draining <= 1'b0;
        end else if (issue_en) begin
            if (count == tap_last) begin
                count    <= '0;             // Restart for drain
                draining <= 1'b1;
            end else begin
                count    <= count + 3'd1;
            end
        end else if (draining) begin
            if (count == drain_last) begin
                count    <= '0;
                draining <= 1'b0;           // Back to idle
            end else begin
                count    <= count + 3'd1;
            end
        end else begin
            count <= '0;                    // Idle, tap 0 ready for next sample
        end
    end

    assign tap        = count;
    assign issue_done = issue_en && (count == tap_last);
    assign drain_done = draining && (count == drain_last);

endmodule

/* design/tap_operands.sv */
`timescale 1ns/1ps

module tap_operands #(
    parameter lpf_pkg::coef_t b0 = '0,          // Feed-forward taps
    parameter lpf_pkg::coef_t b1 = '0,
    parameter lpf_pkg::coef_t b2 = '0,
    parameter lpf_pkg::coef_t a1 = '0,          // Feedback taps, subtracted
    parameter lpf_pkg::coef_t a2 = '0
) (
    input  logic              clk,
    input  logic              reset,
    input  lpf_pkg::sample_t  in_sample,
    input  logic              load_x,           // Accepted input sample
    input  logic              issue_en,
    input  lpf_pkg::tap_t     tap,
    input  logic              y_valid,          // New output, shift history
    input  lpf_pkg::sample_t  y_sample,
    output lpf_pkg::mac_cmd_t cmd
);

    localparam int ext_w = lpf_pkg::coef_w - lpf_pkg::sample_w;

    lpf_pkg::sample_t x0;
    lpf_pkg::sample_t x1;
    lpf_pkg::sample_t x2;
    lpf_pkg::sample_t y1;
    lpf_pkg::sample_t y2;
    lpf_pkg::sample_t opnd;             // Sample picked for this tap

    // ----------------------------------------
    // History
    // ----------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            x0 <= '0;
            x1 <= '0;
            x2 <= '0;
            y1 <= '0;
            y2 <= '0;
        end else begin
            if (load_x) begin
                x0 <= in_sample;
            end
            if (y_valid) begin          // x0 still holds the sample just filtered
                x1 <= x0;
                x2 <= x1;
                y1 <= y_sample;
                y2 <= y1;
            end
        end
    end

    // ----------------------------------------
    // Command per tap
    // ----------------------------------------
    always_comb begin
        cmd.op   = lpf_pkg::op_nop;
        cmd.coef = '0;
        cmd.last = 1'b0;
        opnd     = '0;
        if (issue_en) begin
            case (tap)
                3'd0: begin cmd.op = lpf_pkg::op_load; cmd.coef = b0; opnd = x0; end
                3'd1: begin cmd.op = lpf_pkg::op_add;  cmd.coef = b1; opnd = x1; end
                3'd2: begin cmd.op = lpf_pkg::op_add;  cmd.coef = b2; opnd = x2; end
                3'd3: begin cmd.op = lpf_pkg::op_sub;  cmd.coef = a1; opnd = y1; end
                3'd4: begin
                    cmd.op   = lpf_pkg::op_sub;
                    cmd.coef = a2;
                    opnd     = y2;
                    cmd.last = 1'b1;    // Sum complete after this one
                end
                default: begin
                    cmd.op = lpf_pkg::op_nop;
                end
            endcase
        end
        cmd.data = {{ext_w{opnd[lpf_pkg::sample_w-1]}}, opnd};  // Sign extend
    end

endmodule

/* design/mac_slice.sv */
`timescale 1ns/1ps

module mac_slice (
    input  logic                 clk,
    input  logic                 reset,
    input  lpf_pkg::mac_cmd_t    cmd,       // New command every cycle
    output lpf_pkg::mac_result_t result     // Three cycles behind cmd
);

    localparam int prod_w = 2 * lpf_pkg::coef_w;

    // Stage 1, operand and opcode register
    lpf_pkg::mac_op_t         op_a;
    lpf_pkg::coef_t           coef_a;
    logic signed [lpf_pkg::coef_w-1:0] data_a;
    logic                     last_a;

    // Stage 2, product register
    lpf_pkg::mac_op_t         op_m;
    logic signed [prod_w-1:0] prod_m;
    logic                     last_m;

    // Stage 3, accumulator register
    lpf_pkg::acc_t            acc_p;
    logic                     last_p;
    lpf_pkg::acc_t            prod_ext;

    // ----------------------------------------
    // Operand and product stages
    // ----------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            op_a   <= lpf_pkg::op_nop;
            coef_a <= '0;
            data_a <= '0;
            last_a <= 1'b0;
            op_m   <= lpf_pkg::op_nop;
            prod_m <= '0;
            last_m <= 1'b0;
        end else begin
            op_a   <= cmd.op;
            coef_a <= cmd.coef;
            data_a <= cmd.data;
            last_a <= cmd.last;
            op_m   <= op_a;                 // Opcode follows its product
            prod_m <= coef_a * data_a;      // 18x18 signed
            last_m <= last_a;
        end
    end

    assign prod_ext = lpf_pkg::acc_t'(prod_m);  // Sign extend to 48

    // ----------------------------------------
    // Accumulator
    // ----------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            acc_p  <= '0;
            last_p <= 1'b0;
        end else begin
            case (op_m)
                lpf_pkg::op_load: acc_p <= prod_ext;
                lpf_pkg::op_add:  acc_p <= acc_p + prod_ext;
                lpf_pkg::op_sub:  acc_p <= acc_p - prod_ext;
                default:          acc_p <= acc_p;           // op_nop holds
            endcase
            last_p <= last_m;
        end
    end

    assign result.acc  = acc_p;
    assign result.last = last_p;

endmodule

/* design/output_quantizer.sv */
`timescale 1ns/1ps

module output_quantizer (
    input  logic                 clk,
    input  logic                 reset,
    input  lpf_pkg::mac_result_t result,
    output logic                 out_valid,     // One cycle per sample
    output lpf_pkg::sample_t     out_sample
);

    localparam lpf_pkg::acc_t half   = lpf_pkg::acc_t'(1) <<< (lpf_pkg::coef_frac - 1);
    localparam lpf_pkg::acc_t sat_hi = lpf_pkg::acc_t'((2 ** (lpf_pkg::sample_w - 1)) - 1);
    localparam lpf_pkg::acc_t sat_lo = -sat_hi - lpf_pkg::acc_t'(1);

    lpf_pkg::acc_t    acc_in;
    lpf_pkg::acc_t    shifted;          // Rounded, back to sample scale
    lpf_pkg::sample_t clipped;

    always_comb begin
        acc_in  = result.acc;
        shifted = (acc_in + half) >>> lpf_pkg::coef_frac;  // Round half up
        if (shifted > sat_hi) begin
            clipped = lpf_pkg::sample_t'(sat_hi);           // Clip positive
        end else if (shifted < sat_lo) begin
            clipped = lpf_pkg::sample_t'(sat_lo);           // Clip negative
        end else begin
            clipped = lpf_pkg::sample_t'(shifted);
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            out_valid  <= 1'b0;
            out_sample <= '0;
        end else begin
            out_valid <= result.last;
            if (result.last) begin
                out_sample <= clipped;      // Held until next sample
            end
        end
    end

endmodule

/* design/iir_lpf_top.sv */
`timescale 1ns/1ps

module iir_lpf_top #(
    // Butterworth low-pass near fs/10, Q2.16, DC gain about 1
    parameter lpf_pkg::coef_t b0 = 18'sd4421,
    parameter lpf_pkg::coef_t b1 = 18'sd8842,
    parameter lpf_pkg::coef_t b2 = 18'sd4421,
    parameter lpf_pkg::coef_t a1 = -18'sd74907,
    parameter lpf_pkg::coef_t a2 = 18'sd27053
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             in_valid,
    input  lpf_pkg::sample_t in_sample,
    output logic             busy,
    output logic             out_valid,
    output lpf_pkg::sample_t out_sample
);

    logic                 load_x;
    logic                 issue_en;
    logic                 issue_done;
    logic                 drain_done;
    lpf_pkg::tap_t        tap;
    lpf_pkg::mac_cmd_t    cmd;
    lpf_pkg::mac_result_t result;

    // ----------------------------------------
    // Control
    // ----------------------------------------
    lpf_sequencer u_lpf_sequencer (
        .clk        (clk       ),
        .reset      (reset     ),
        .in_valid   (in_valid  ),
        .issue_done (issue_done),
        .drain_done (drain_done),
        .load_x     (load_x    ),
        .issue_en   (issue_en  ),
        .busy       (busy      )
    );

    tap_counter u_tap_counter (
        .clk        (clk       ),
        .reset      (reset     ),
        .issue_en   (issue_en  ),
        .tap        (tap       ),
        .issue_done (issue_done),
        .drain_done (drain_done)
    );

    // ----------------------------------------
    // Datapath
    // ----------------------------------------
    tap_operands #(
        .b0 (b0),
        .b1 (b1),
        .b2 (b2),
        .a1 (a1),
        .a2 (a2)
    ) u_tap_operands (
        .clk       (clk       ),
        .reset     (reset     ),
        .in_sample (in_sample ),
        .load_x    (load_x    ),
        .issue_en  (issue_en  ),
        .tap       (tap       ),
        .y_valid   (out_valid ),    // Output strobe shifts the history
        .y_sample  (out_sample),
        .cmd       (cmd       )
    );

    mac_slice u_mac_slice (
        .clk    (clk   ),
        .reset  (reset ),
        .cmd    (cmd   ),
        .result (result)
    );

    output_quantizer u_output_quantizer (
        .clk        (clk       ),
        .reset      (reset     ),
        .result     (result    ),
        .out_valid  (out_valid ),
        .out_sample (out_sample)
    );

endmodule

/* bench/lpf_clock_gen.sv */
`timescale 1ns/1ps

module lpf_clock_gen (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;         // 20 ns period
    end

    initial begin
        reset = 1'b1;
        repeat (2) @(posedge clk);      // Held for two rising edges
        reset <= 1'b0;
    end

endmodule

/* bench/tb_iir_lpf.sv */
`timescale 1ns/1ps

module tb_iir_lpf;

    // ----------------------------------------
    // Test sizes and limits
    // ----------------------------------------
    localparam int impulse_count  = 31;     // Impulse plus 30 zeros
    localparam int random_count   = 300;
    localparam int drop_count     = 40;
    localparam int sat_count      = 60;     // Three runs of 20
    localparam int total_count    = impulse_count + random_count + drop_count + sat_count;
    localparam int timeout_cycles = 2 * total_count * 10 + 200;
    localparam int latency_exp    = 9;      // Accepting edge to out_valid

    // Filter coefficients in Q2.16
    localparam longint b0_m = 4421;
    localparam longint b1_m = 8842;
    localparam longint b2_m = 4421;
    localparam longint a1_m = -74907;
    localparam longint a2_m = 27053;

    logic             clk;
    logic             reset;
    logic             in_valid;
    lpf_pkg::sample_t in_sample;
    logic             busy;
    logic             out_valid;
    lpf_pkg::sample_t out_sample;

    lpf_pkg::sample_t exp_q[$];             // Expected outputs in order
    string            name_q[$];            // Test owning each output
    int               accept_q[$];          // Accepting edge of each sample
    string            test_name;
    int               cycle            = 0; // Rising edges seen so far
    int               busy_check_cycle = -1;
    longint           mx1 = 0;              // Model history
    longint           mx2 = 0;
    longint           my1 = 0;
    longint           my2 = 0;

    lpf_clock_gen u_lpf_clock_gen (
        .clk   (clk  ),
        .reset (reset)
    );

    iir_lpf_top u_iir_lpf_top (
        .clk        (clk       ),
        .reset      (reset     ),
        .in_valid   (in_valid  ),
        .in_sample  (in_sample ),
        .busy       (busy      ),
        .out_valid  (out_valid ),
        .out_sample (out_sample)
    );

    // ----------------------------------------
    // Checks
    // ----------------------------------------
    task automatic stop_with_failure();
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic check_sample(input string name, input lpf_pkg::sample_t exp,
                                input lpf_pkg::sample_t act);
        if (act !== exp) begin
            $display("** Error: %s sample expected %0d actual %0d", name, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic check_latency(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("** Error: %s latency expected %0d actual %0d", name, exp, act);
            stop_with_failure();
        end
    endtask

    function automatic int pick_in_range(input int lo, input int hi);
        return lo + int'($urandom % unsigned'(hi - lo + 1));
    endfunction

    // ----------------------------------------
    // Biquad model, direct form I
    // ----------------------------------------
    task automatic model_filter(input lpf_pkg::sample_t x, output lpf_pkg::sample_t y);
        longint acc;
        longint r;
        acc = b0_m * longint'(x) + b1_m * mx1 + b2_m * mx2 - a1_m * my1 - a2_m * my2;
        r   = (acc + 64'sd32768) >>> 16;                // Round half up
        if (r > 32767) begin
            y = lpf_pkg::sample_t'(32767);
        end else if (r < -32768) begin
            y = lpf_pkg::sample_t'(-32768);
        end else begin
            y = lpf_pkg::sample_t'(r);
        end
        mx2 = mx1;
        mx1 = longint'(x);
        my2 = my1;
        my1 = longint'(y);                              // Clipped value fed back
    endtask

    // One accepted sample, then gap-1 idle cycles with an optional dropped strobe
    task automatic send_sample(input lpf_pkg::sample_t x, input int gap, input int drop_at);
        lpf_pkg::sample_t y;
        int               i;
        @(posedge clk);
        in_valid  <= 1'b1;
        in_sample <= x;
        model_filter(x, y);
        exp_q.push_back(y);
        name_q.push_back(test_name);
        accept_q.push_back(cycle + 1);                  // DUT samples on the next edge
        for (i = 1; i < gap; i++) begin
            @(posedge clk);
            in_valid <= (i == drop_at);                 // Lands while busy, must be lost
            if (i == drop_at) begin
                in_sample <= lpf_pkg::sample_t'($urandom);
            end
        end
    endtask

    task automatic collect_output();
        lpf_pkg::sample_t want;
        string            name;
        int               accepted;
        if (exp_q.size() == 0) begin
            $display("out_valid arrived with no sample outstanding at cycle %0d", cycle);
            stop_with_failure();
        end else begin
            want     = exp_q.pop_front();
            name     = name_q.pop_front();
            accepted = accept_q.pop_front();
            check_sample(name, want, out_sample);
            check_latency(name, latency_exp, cycle - accepted);
            busy_check_cycle = cycle + 1;               // busy must be low here
        end
    endtask

    // ----------------------------------------
    // Monitor and timeout
    // ----------------------------------------
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= timeout_cycles) begin
            $display("Run stopped after %0d cycles with outputs still missing", cycle);
            stop_with_failure();
        end
        if (cycle == busy_check_cycle && busy) begin
            $display("busy still high one cycle after out_valid, cycle %0d", cycle);
            stop_with_failure();
        end
        if (out_valid) begin
            collect_output();
        end
    end

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    initial begin
        int i;
        in_valid  = 1'b0;
        in_sample = '0;
        void'($urandom(59187));
        wait (reset == 1'b0);
        repeat (2) @(posedge clk);

        test_name = "impulse";
        send_sample(lpf_pkg::sample_t'(16384), 10, 0);
        repeat (impulse_count - 1) send_sample(lpf_pkg::sample_t'(0), 10, 0);

        test_name = "random";
        repeat (random_count) begin
            send_sample(lpf_pkg::sample_t'($urandom), pick_in_range(10, 14), 0);
        end

        test_name = "dropped";
        repeat (drop_count) begin
            send_sample(lpf_pkg::sample_t'($urandom), pick_in_range(10, 14),
                        pick_in_range(1, 8));
        end

        test_name = "saturation";
        for (i = 0; i < sat_count / 3; i++) begin       // Alternating full scale
            send_sample((i % 2 == 0) ? lpf_pkg::sample_t'(32767)
                                     : lpf_pkg::sample_t'(-32768), 10, 0);
        end
        repeat (sat_count / 3) send_sample(lpf_pkg::sample_t'(32767), 10, 0);
        repeat (sat_count / 3) send_sample(lpf_pkg::sample_t'(-32768), 10, 0);

        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);                      // Let the busy check run

        $display("Regression passed");
        $finish;
    end

endmodule

/* compile.f */
design/lpf_pkg.sv
design/lpf_sequencer.sv
design/tap_counter.sv
design/tap_operands.sv
design/mac_slice.sv
design/output_quantizer.sv
design/iir_lpf_top.sv
bench/lpf_clock_gen.sv
bench/tb_iir_lpf.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_iir_lpf
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the bench with Verilator, run it and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

test: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Regression failed" $(LOG); then echo "TEST FAILED"; exit 1; fi
	@if ! grep -q "Regression passed" $(LOG); then echo "TEST INCOMPLETE"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
